/* hdl/jx2Dec_macros.svh */
// Widths, micro-commands, form ids and encodings of the 16-bit decode stage.
// Also the bank prefixes and the special register numbers.

`ifndef JX2DEC_MACROS_SVH
`define JX2DEC_MACROS_SVH

`define JX2_REG_W	7
`define JX2_IMM_W	33
`define JX2_UCMD_W	8
`define JX2_FMID_W	5
`define JX2_BTY_W	3
`define JX2_IXT_W	4

`define JX2_BANK_GPR	3'd0
`define JX2_BANK_EXT	3'd1
`define JX2_BANK_CR	3'd2
`define JX2_BANK_SR	3'd4

// DLR and SP alias R0 and R15. IMM and ZZR are pseudo registers in the SR bank.
`define JX2_REG_DLR	{`JX2_BANK_GPR, 4'h0}
`define JX2_REG_SP	{`JX2_BANK_GPR, 4'hF}
`define JX2_REG_PC	{`JX2_BANK_CR, 4'h0}
`define JX2_REG_IMM	{`JX2_BANK_SR, 4'hE}
`define JX2_REG_ZZR	{`JX2_BANK_SR, 4'hF}

`define JX2_UCMD_INVOP	8'h00
`define JX2_UCMD_NOP	8'h01
`define JX2_UCMD_OP_IXT	8'h02
`define JX2_UCMD_MOV_RR	8'h03

// Byte, word, long and quad moves are consecutive in each direction.
`define JX2_UCMD_MOVB_RM	8'h04
`define JX2_UCMD_MOVW_RM	8'h05
`define JX2_UCMD_MOVL_RM	8'h06
`define JX2_UCMD_MOVQ_RM	8'h07
`define JX2_UCMD_MOVB_MR	8'h08
`define JX2_UCMD_MOVW_MR	8'h09
`define JX2_UCMD_MOVL_MR	8'h0A
`define JX2_UCMD_MOVQ_MR	8'h0B

`define JX2_UCMD_ALU_ADD	8'h10
`define JX2_UCMD_ALU_SUB	8'h11
`define JX2_UCMD_ALU_ADC	8'h12
`define JX2_UCMD_ALU_SBB	8'h13
`define JX2_UCMD_ALU_TST	8'h14
`define JX2_UCMD_ALU_AND	8'h15
`define JX2_UCMD_ALU_OR	8'h16
`define JX2_UCMD_ALU_XOR	8'h17
`define JX2_UCMD_ALU_CMPEQ	8'h18
`define JX2_UCMD_ALU_CMPHI	8'h19
`define JX2_UCMD_ALU_CMPGT	8'h1A
`define JX2_UCMD_ALU_CMPGE	8'h1B

// Base of the single-register block 0x20..0x2A, in the order
// NOT, NEG, NEGC, MOVNT, ROTL, ROTR, ROTCL, ROTCR, SHLL, SHLR, SHAR.
`define JX2_UCMD_ALU_NOT	8'h20

`define JX2_UCMD_ALU_LDIX	8'h30
`define JX2_UCMD_ALU_LDISH	8'h31
`define JX2_UCMD_ALU_LDISH16	8'h32
`define JX2_UCMD_MOV_IR	8'h33

`define JX2_UCMD_ALU_SHLLN	8'h38
`define JX2_UCMD_ALU_SHLRN	8'h39
`define JX2_UCMD_ALU_SHARN	8'h3A
`define JX2_UCMD_ALU_SHARSX	8'h3B

`define JX2_UCMD_CF_BRA	8'h40
`define JX2_UCMD_CF_BSR	8'h41
`define JX2_UCMD_CF_BT	8'h42
`define JX2_UCMD_CF_BF	8'h43

`define JX2_UCMD_IX_RTS	8'h00
`define JX2_UCMD_IX_SLEEP	8'h01
`define JX2_UCMD_IX_BREAK	8'h02
`define JX2_UCMD_IX_CLRT	8'h03
`define JX2_UCMD_IX_SETT	8'h04
`define JX2_UCMD_IX_CLRS	8'h05
`define JX2_UCMD_IX_SETS	8'h06
`define JX2_UCMD_IX_NOTT	8'h07
`define JX2_UCMD_IX_NOTS	8'h08
`define JX2_UCMD_IX_RTE	8'h09

`define JX2_FMID_INV	5'd0
`define JX2_FMID_Z	5'd1
`define JX2_FMID_REG	5'd2
`define JX2_FMID_REGREG	5'd3
`define JX2_FMID_IMM8REG	5'd4
`define JX2_FMID_IMM8Z	5'd5
`define JX2_FMID_IMM8N	5'd6
`define JX2_FMID_IMM12Z	5'd7
`define JX2_FMID_IMM12N	5'd8
`define JX2_FMID_IMM4ZREG	5'd9
`define JX2_FMID_IMM4NREG	5'd10
`define JX2_FMID_REGSTREG	5'd11
`define JX2_FMID_LDREGREG	5'd12
`define JX2_FMID_REGSTDRREG	5'd13
`define JX2_FMID_LDDRREGREG	5'd14
`define JX2_FMID_PCDISP8	5'd15
`define JX2_FMID_REGSTDI4SP	5'd16
`define JX2_FMID_LDDI4SPREG	5'd17

`define JX2_BTY_SB	3'd0
`define JX2_BTY_SW	3'd1
`define JX2_BTY_SL	3'd2
`define JX2_BTY_SQ	3'd3
`define JX2_BTY_UB	3'd4
`define JX2_BTY_UW	3'd5
`define JX2_BTY_UL	3'd6
`define JX2_BTY_UQ	3'd7

`define JX2_IXT_REG	4'd0
`define JX2_IXT_RDL	4'd1
`define JX2_IXT_RDI	4'd2

`endif

/* hdl/jx2DecPkg.sv */
// Types shared by the decode stage and its testbench.
// The extension word has a memory view and a raw command-index view.

`include "jx2Dec_macros.svh"

package jx2DecPkg;

	// Addressing mode, direction and access width of a memory or branch form.
	typedef struct packed {
		logic [`JX2_IXT_W-1:0] mode;
		logic isLoad;
		logic [`JX2_BTY_W-1:0] bty;
	} uIxtMem;

	typedef union packed {
		uIxtMem mem;
		logic [7:0] cmdIx;	// Sub-op or shift amount.
	} uIxtWord;

endpackage

/* hdl/jx2OpTable.sv */
// Opcode table for the 16-bit instruction forms.
// Classifies a word into micro-command, operand form, width code and index.

`timescale 1ns/1ps

`include "jx2Dec_macros.svh"

module jx2OpTable (
	input logic [15:0] istrWord,
	output logic [`JX2_UCMD_W-1:0] opUCmd,
	output logic [`JX2_FMID_W-1:0] opFmid,
	output logic [`JX2_BTY_W-1:0] opBty,
	output logic [7:0] opUCmdIx
);

	always_comb begin
		opUCmd = `JX2_UCMD_INVOP;
		opFmid = `JX2_FMID_INV;
		opBty = '0;
		opUCmdIx = '0;

		casez (istrWord)
			16'h0zzz: begin
				opBty = {1'b0, istrWord[9:8]};
				// Bit 11 is the load bit, bit 10 adds DLR to the address.
				case (istrWord[11:10])
					2'b00: opFmid = `JX2_FMID_REGSTREG;
					2'b01: opFmid = `JX2_FMID_REGSTDRREG;
					2'b10: opFmid = `JX2_FMID_LDREGREG;
					default: opFmid = `JX2_FMID_LDDRREGREG;
				endcase
				if (istrWord[11]) begin
					opUCmd = `JX2_UCMD_MOVB_MR + {6'b0, istrWord[9:8]};
				end else begin
					opUCmd = `JX2_UCMD_MOVB_RM + {6'b0, istrWord[9:8]};
				end
			end
			16'b0001_0zzz_zzzz_zzzz: begin
				opUCmd = `JX2_UCMD_ALU_ADD + {5'b0, istrWord[10:8]};	// ADD to XOR.
				opFmid = `JX2_FMID_REGREG;
			end
			16'b0001_10zz_zzzz_zzzz: begin
				opUCmd = `JX2_UCMD_MOV_RR;
				opFmid = `JX2_FMID_REGREG;
				opBty = {1'b0, istrWord[9:8]};	// Selects which side uses the EXT bank.
			end
			16'b0001_11zz_zzzz_zzzz: begin
				if (istrWord[9:8] != 2'b11) begin
					opUCmd = `JX2_UCMD_ALU_CMPEQ + {6'b0, istrWord[9:8]};
					opFmid = `JX2_FMID_REGREG;
				end
			end
			16'b0010_00zz_zzzz_zzzz: begin
				opUCmd = `JX2_UCMD_CF_BRA + {6'b0, istrWord[9:8]};
				opFmid = `JX2_FMID_PCDISP8;
				opBty = `JX2_BTY_SW;
			end
			16'h24zz, 16'h25zz: begin
				opUCmd = `JX2_UCMD_ALU_LDIX;
				opFmid = istrWord[8] ? `JX2_FMID_IMM8N : `JX2_FMID_IMM8Z;
			end
			16'h26zz: begin
				opUCmd = `JX2_UCMD_ALU_LDISH;
				opFmid = `JX2_FMID_IMM8Z;
			end
			16'b0010_10zz_zzzz_zzzz: begin
				// SP displacement, long or quad, store or load.
				opBty = istrWord[8] ? `JX2_BTY_SQ : `JX2_BTY_SL;
				if (istrWord[9]) begin
					opUCmd = `JX2_UCMD_MOVL_MR + {7'b0, istrWord[8]};
					opFmid = `JX2_FMID_LDDI4SPREG;
				end else begin
					opUCmd = `JX2_UCMD_MOVL_RM + {7'b0, istrWord[8]};
					opFmid = `JX2_FMID_REGSTDI4SP;
				end
			end
			16'h2Czz, 16'h2Dzz: begin
				opUCmd = `JX2_UCMD_ALU_CMPEQ;
				opFmid = istrWord[8] ? `JX2_FMID_IMM4NREG : `JX2_FMID_IMM4ZREG;
			end
			16'h2Ezz: begin
				opUCmd = `JX2_UCMD_ALU_CMPGT;
				opFmid = `JX2_FMID_IMM4ZREG;
			end
			16'h2Fzz: begin
				opUCmd = `JX2_UCMD_ALU_CMPGE;
				opFmid = `JX2_FMID_IMM4ZREG;
			end
			16'h30z0: begin
				opUCmd = `JX2_UCMD_OP_IXT;
				opFmid = `JX2_FMID_Z;
				case (istrWord[7:4])
					4'h0: opUCmd = `JX2_UCMD_NOP;
					4'h1: opUCmdIx = `JX2_UCMD_IX_RTS;
					4'h2: opUCmdIx = `JX2_UCMD_IX_SLEEP;
					4'h3: opUCmdIx = `JX2_UCMD_IX_BREAK;
					4'h4: opUCmdIx = `JX2_UCMD_IX_CLRT;
					4'h5: opUCmdIx = `JX2_UCMD_IX_SETT;
					4'h6: opUCmdIx = `JX2_UCMD_IX_CLRS;
					4'h7: opUCmdIx = `JX2_UCMD_IX_SETS;
					4'h8: opUCmdIx = `JX2_UCMD_IX_NOTT;
					4'h9: opUCmdIx = `JX2_UCMD_IX_NOTS;
					4'hA, 4'hB: opUCmd = `JX2_UCMD_ALU_LDISH16;
					4'hC: opUCmdIx = `JX2_UCMD_IX_RTE;
					default: begin
						opUCmd = `JX2_UCMD_INVOP;
						opFmid = `JX2_FMID_INV;
					end
				endcase
			end
			16'h33zz: begin
				if (istrWord[3:0] <= 4'hA) begin
					opUCmd = `JX2_UCMD_ALU_NOT + {4'b0, istrWord[3:0]};
					opFmid = `JX2_FMID_REG;
				end
			end
			16'h34zz: begin
				opFmid = `JX2_FMID_REG;
				if (istrWord[3:0] == 4'hF) begin
					opUCmd = `JX2_UCMD_ALU_SHARSX;
					opUCmdIx = 8'd63;
				end else if (istrWord[3:2] == 2'b11) begin
					opUCmd = `JX2_UCMD_ALU_SHLLN + {6'b0, istrWord[1:0]};
					opUCmdIx = 8'd16;
				end else begin
					// Kind in bits 3:2, amount 1, 2, 4 or 8 in bits 1:0.
					opUCmd = `JX2_UCMD_ALU_SHLLN + {6'b0, istrWord[3:2]};
					opUCmdIx = 8'd1 << istrWord[1:0];
				end
			end
			16'hAzzz: begin
				opUCmd = `JX2_UCMD_ALU_LDIX;
				opFmid = `JX2_FMID_IMM12Z;
			end
			16'hBzzz: begin
				opUCmd = `JX2_UCMD_ALU_LDIX;
				opFmid = `JX2_FMID_IMM12N;
			end
			16'hCzzz: begin
				opUCmd = `JX2_UCMD_ALU_ADD;
				opFmid = `JX2_FMID_IMM8REG;
			end
			16'hEzzz: begin
				opUCmd = `JX2_UCMD_MOV_IR;
				opFmid = `JX2_FMID_IMM8REG;
			end
			default: opFmid = `JX2_FMID_INV;	// Dropped groups stay invalid.
		endcase
	end

endmodule

/* hdl/jx2OperandForm.sv */
// Operand builder for the decoded form.
// Produces register selectors, the immediate and the extension word.

`timescale 1ns/1ps

`include "jx2Dec_macros.svh"

module jx2OperandForm (
	input logic [15:0] istrWord,
	input logic [`JX2_FMID_W-1:0] opFmid,
	input logic [`JX2_BTY_W-1:0] opBty,
	input logic [7:0] opUCmdIx,
	output logic [`JX2_REG_W-1:0] regN,
	output logic [`JX2_REG_W-1:0] regM,
	output logic [`JX2_REG_W-1:0] regO,
	output logic [`JX2_IMM_W-1:0] imm,
	output jx2DecPkg::uIxtWord uIxt
);

	logic [`JX2_REG_W-1:0] gprO;
	logic [`JX2_REG_W-1:0] gprN;
	logic [`JX2_REG_W-1:0] gprM;
	logic [`JX2_REG_W-1:0] extN;
	logic [`JX2_REG_W-1:0] extM;
	logic [`JX2_IMM_W-1:0] spDisp;

	assign gprO = {`JX2_BANK_GPR, istrWord[11:8]};
	assign gprN = {`JX2_BANK_GPR, istrWord[7:4]};
	assign gprM = {`JX2_BANK_GPR, istrWord[3:0]};
	assign extN = {`JX2_BANK_EXT, istrWord[7:4]};
	assign extM = {`JX2_BANK_EXT, istrWord[3:0]};

	// Quad accesses scale the 4-bit displacement into the upper half of the frame.
	assign spDisp = {28'b0, opBty == `JX2_BTY_SQ, istrWord[3:0]};

	always_comb begin
		regN = `JX2_REG_ZZR;
		regM = `JX2_REG_ZZR;
		regO = `JX2_REG_ZZR;
		imm = '0;
		uIxt = '0;

		case (opFmid)
			`JX2_FMID_Z: begin
				uIxt.cmdIx = opUCmdIx;
				imm = {17'b0, {16{istrWord[7:4] == 4'hB}}};	// Only 0x30B0 loads 0xFFFF.
			end
			`JX2_FMID_REG: begin
				regN = gprN;
				uIxt.cmdIx = opUCmdIx;
			end
			`JX2_FMID_REGREG: begin
				// SW puts M in the EXT bank, SL puts N there, SQ both.
				regN = opBty[1] ? extN : gprN;
				regM = opBty[0] ? extM : gprM;
				regO = `JX2_REG_DLR;
			end
			`JX2_FMID_IMM8REG: begin
				regN = gprO;
				regM = `JX2_REG_IMM;
				imm = {{(`JX2_IMM_W-8){istrWord[7]}}, istrWord[7:0]};
			end
			`JX2_FMID_IMM8Z, `JX2_FMID_IMM8N: begin
				regN = `JX2_REG_DLR;
				regM = `JX2_REG_IMM;
				imm = {{(`JX2_IMM_W-8){opFmid == `JX2_FMID_IMM8N}}, istrWord[7:0]};
			end
			`JX2_FMID_IMM12Z, `JX2_FMID_IMM12N: begin
				regN = `JX2_REG_DLR;
				regM = `JX2_REG_IMM;
				imm = {{(`JX2_IMM_W-12){opFmid == `JX2_FMID_IMM12N}}, istrWord[11:0]};
			end
			`JX2_FMID_IMM4ZREG, `JX2_FMID_IMM4NREG: begin
				regN = gprN;
				regM = `JX2_REG_IMM;
				imm = {{(`JX2_IMM_W-4){opFmid == `JX2_FMID_IMM4NREG}}, istrWord[3:0]};
			end
			`JX2_FMID_REGSTREG: begin
				regN = gprN;
				regM = gprM;
				uIxt.mem = '{`JX2_IXT_REG, 1'b0, opBty};
			end
			`JX2_FMID_LDREGREG: begin
				regN = gprN;
				regM = gprM;
				uIxt.mem = '{`JX2_IXT_REG, 1'b1, opBty};
			end
			`JX2_FMID_REGSTDRREG: begin
				regN = gprN;
				regM = gprM;
				uIxt.mem = '{`JX2_IXT_RDL, 1'b0, opBty};
			end
			`JX2_FMID_LDDRREGREG: begin
				regN = gprN;
				regM = gprM;
				uIxt.mem = '{`JX2_IXT_RDL, 1'b1, opBty};
			end
			`JX2_FMID_PCDISP8: begin
				regN = `JX2_REG_DLR;
				regM = `JX2_REG_PC;
				imm = {{(`JX2_IMM_W-8){istrWord[7]}}, istrWord[7:0]};
				uIxt.mem = '{`JX2_IXT_RDI, 1'b1, opBty};
			end
			`JX2_FMID_REGSTDI4SP: begin
				regN = `JX2_REG_SP;
				regM = gprN;
				imm = spDisp;
				uIxt.mem = '{`JX2_IXT_RDI, 1'b0, opBty};
			end
			`JX2_FMID_LDDI4SPREG: begin
				regN = gprN;
				regM = `JX2_REG_SP;
				imm = spDisp;
				uIxt.mem = '{`JX2_IXT_RDI, 1'b1, opBty};
			end
			default: begin
			end
		endcase
	end

endmodule

/* hdl/jx2DecOp.sv */
// Registered decode stage for 16-bit instruction words.
// Opcode table and operand builder feed one output register.

`timescale 1ns/1ps

`include "jx2Dec_macros.svh"

module jx2DecOp (
	input logic clock,
	input logic rstN,
	input logic instrValid,
	input logic [15:0] istrWord,
	output logic decValid,
	output logic [`JX2_REG_W-1:0] idRegN,
	output logic [`JX2_REG_W-1:0] idRegM,
	output logic [`JX2_REG_W-1:0] idRegO,
	output logic [`JX2_IMM_W-1:0] idImm,
	output logic [`JX2_UCMD_W-1:0] idUCmd,
	output jx2DecPkg::uIxtWord idUIxt
);

	import jx2DecPkg::*;

	logic [`JX2_UCMD_W-1:0] opUCmd;
	logic [`JX2_FMID_W-1:0] opFmid;
	logic [`JX2_BTY_W-1:0] opBty;
	logic [7:0] opUCmdIx;
	logic [`JX2_REG_W-1:0] regN;
	logic [`JX2_REG_W-1:0] regM;
	logic [`JX2_REG_W-1:0] regO;
	logic [`JX2_IMM_W-1:0] imm;
	uIxtWord uIxt;

	jx2OpTable opTable (
		.istrWord(istrWord),
		.opUCmd(opUCmd),
		.opFmid(opFmid),
		.opBty(opBty),
		.opUCmdIx(opUCmdIx)
	);

	jx2OperandForm operandForm (
		.istrWord(istrWord),
		.opFmid(opFmid),
		.opBty(opBty),
		.opUCmdIx(opUCmdIx),
		.regN(regN),
		.regM(regM),
		.regO(regO),
		.imm(imm),
		.uIxt(uIxt)
	);

	// Outputs hold the last result while no new word arrives.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			decValid <= 1'b0;
			idUCmd <= `JX2_UCMD_NOP;
			idRegN <= `JX2_REG_ZZR;
			idRegM <= `JX2_REG_ZZR;
			idRegO <= `JX2_REG_ZZR;
			idImm <= '0;
			idUIxt <= '0;
		end else begin
			decValid <= instrValid;
			if (instrValid) begin
				idUCmd <= opUCmd;
				idRegN <= regN;
				idRegM <= regM;
				idRegO <= regO;
				idImm <= imm;
				idUIxt <= uIxt;
			end
		end
	end

endmodule

/* sim/tbClockGen.sv */
// Clock and reset generator for the decode stage testbench.
// 40 ns clock period, reset held low for the first three rising edges.

`timescale 1ns/1ps

module tbClockGen (
	output logic clock,
	output logic rstN
);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial begin
		rstN = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;	// Released between edges, like the other inputs.
	end

endmodule

/* sim/jx2DecOp_assert.sv */
// Concurrent checks on the decode stage handshake and invalid results.
// Bound to jx2DecOp from the testbench top.

`timescale 1ns/1ps

`include "jx2Dec_macros.svh"

module jx2DecOpAssert (
	input logic clock,
	input logic rstN,
	input logic instrValid,
	input logic decValid,
	input logic [`JX2_UCMD_W-1:0] idUCmd,
	input logic [`JX2_REG_W-1:0] idRegN,
	input logic [`JX2_REG_W-1:0] idRegM,
	input logic [`JX2_REG_W-1:0] idRegO,
	input logic [`JX2_IMM_W-1:0] idImm,
	input jx2DecPkg::uIxtWord idUIxt
);

	logic started = 1'b0;	// Masks the first edge, where no history exists yet.

	always_ff @(posedge clock) started <= 1'b1;

	validDelay: assert property (@(posedge clock) disable iff (!rstN)
		$past(rstN) |-> (decValid == $past(instrValid)))
		else $error("decValid does not follow instrValid by one cycle");

	invalidCleared: assert property (@(posedge clock) disable iff (!rstN)
		(decValid && idUCmd == `JX2_UCMD_INVOP) |->
		(idRegN == `JX2_REG_ZZR && idRegM == `JX2_REG_ZZR && idRegO == `JX2_REG_ZZR
		&& idImm == '0 && idUIxt == '0))
		else $error("Invalid word decoded with live operand fields");

	validAfterReset: assert property (@(posedge clock)
		(started && !$past(rstN)) |-> !decValid)
		else $error("decValid high in the cycle after reset");

endmodule

/* sim/tbJx2DecOp.sv */
// Testbench top for the 16-bit decode stage.
// LFSR stimulus, reference decoder, result queue, compare tasks and report.

`timescale 1ns/1ps

`include "jx2Dec_macros.svh"

module tbJx2DecOp;

	import jx2DecPkg::*;

	typedef struct packed {
		logic [15:0] word;
		logic [`JX2_UCMD_W-1:0] ucmd;
		logic [`JX2_REG_W-1:0] regN;
		logic [`JX2_REG_W-1:0] regM;
		logic [`JX2_REG_W-1:0] regO;
		logic [`JX2_IMM_W-1:0] imm;
		uIxtWord ixt;
	} decResult;

	logic clock;
	logic rstN;
	logic instrValid;
	logic [15:0] istrWord;
	logic decValid;
	logic [`JX2_REG_W-1:0] idRegN;
	logic [`JX2_REG_W-1:0] idRegM;
	logic [`JX2_REG_W-1:0] idRegO;
	logic [`JX2_IMM_W-1:0] idImm;
	logic [`JX2_UCMD_W-1:0] idUCmd;
	uIxtWord idUIxt;

	decResult expQ[$];
	logic [15:0] lfsr;
	int sentCount = 0;
	int resultCount = 0;
	int errUCmd = 0;
	int errReg = 0;
	int errImm = 0;
	int errIxt = 0;
	int errOther = 0;
	int timeouts = 0;

	tbClockGen clockGen (.clock(clock), .rstN(rstN));

	jx2DecOp dut (
		.clock(clock),
		.rstN(rstN),
		.instrValid(instrValid),
		.istrWord(istrWord),
		.decValid(decValid),
		.idRegN(idRegN),
		.idRegM(idRegM),
		.idRegO(idRegO),
		.idImm(idImm),
		.idUCmd(idUCmd),
		.idUIxt(idUIxt)
	);

	bind jx2DecOp jx2DecOpAssert decAssert (
		.clock(clock), .rstN(rstN), .instrValid(instrValid), .decValid(decValid),
		.idUCmd(idUCmd), .idRegN(idRegN), .idRegM(idRegM), .idRegO(idRegO),
		.idImm(idImm), .idUIxt(idUIxt)
	);

	// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic randBits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	function automatic decResult refDecode(input logic [15:0] w);
		decResult r;
		decResult inv;
		logic ok;
		logic [3:0] n3;
		logic [3:0] n2;
		logic [3:0] n1;
		logic [3:0] n0;
		{n3, n2, n1, n0} = w;
		inv.word = w;
		inv.ucmd = `JX2_UCMD_INVOP;
		inv.regN = `JX2_REG_ZZR;
		inv.regM = `JX2_REG_ZZR;
		inv.regO = `JX2_REG_ZZR;
		inv.imm = '0;
		inv.ixt = '0;
		r = inv;
		ok = 1'b1;
		case (n3)
			4'h0: begin
				r.ucmd = (n2[3] ? `JX2_UCMD_MOVB_MR : `JX2_UCMD_MOVB_RM) + {6'b0, n2[1:0]};
				r.regN = {`JX2_BANK_GPR, n1};
				r.regM = {`JX2_BANK_GPR, n0};
				r.ixt.mem.mode = n2[2] ? `JX2_IXT_RDL : `JX2_IXT_REG;
				r.ixt.mem.isLoad = n2[3];
				r.ixt.mem.bty = `JX2_BTY_SB + {1'b0, n2[1:0]};
			end
			4'h1: begin
				r.regN = {(n2 == 4'hA || n2 == 4'hB) ? `JX2_BANK_EXT : `JX2_BANK_GPR, n1};
				r.regM = {(n2 == 4'h9 || n2 == 4'hB) ? `JX2_BANK_EXT : `JX2_BANK_GPR, n0};
				r.regO = `JX2_REG_DLR;
				if (n2 < 4'h8) r.ucmd = `JX2_UCMD_ALU_ADD + {4'b0, n2};
				else if (n2 < 4'hC) r.ucmd = `JX2_UCMD_MOV_RR;
				else if (n2 < 4'hF) r.ucmd = `JX2_UCMD_ALU_CMPEQ + {4'b0, n2 - 4'hC};
				else ok = 1'b0;
			end
			4'h2: begin
				if (n2 < 4'h4) begin
					r.ucmd = `JX2_UCMD_CF_BRA + {4'b0, n2};
					r.regN = `JX2_REG_DLR;
					r.regM = `JX2_REG_PC;
					r.imm = {{(`JX2_IMM_W-8){w[7]}}, w[7:0]};
					r.ixt.mem = '{`JX2_IXT_RDI, 1'b1, `JX2_BTY_SW};
				end else if (n2 < 4'h7) begin
					r.ucmd = (n2 == 4'h6) ? `JX2_UCMD_ALU_LDISH : `JX2_UCMD_ALU_LDIX;
					r.regN = `JX2_REG_DLR;
					r.regM = `JX2_REG_IMM;
					r.imm = {{(`JX2_IMM_W-8){n2 == 4'h5}}, w[7:0]};
				end else if (n2 == 4'h7) begin
					ok = 1'b0;
				end else if (n2 < 4'hC) begin
					// Bit 9 picks the load, bit 8 the quad width.
					r.ucmd = (n2[1] ? `JX2_UCMD_MOVL_MR : `JX2_UCMD_MOVL_RM) + {7'b0, n2[0]};
					r.regN = n2[1] ? {`JX2_BANK_GPR, n1} : `JX2_REG_SP;
					r.regM = n2[1] ? `JX2_REG_SP : {`JX2_BANK_GPR, n1};
					r.imm = {28'b0, n2[0], n0};
					r.ixt.mem = '{`JX2_IXT_RDI, n2[1], n2[0] ? `JX2_BTY_SQ : `JX2_BTY_SL};
				end else begin
					if (n2 < 4'hE) r.ucmd = `JX2_UCMD_ALU_CMPEQ;
					else if (n2 == 4'hE) r.ucmd = `JX2_UCMD_ALU_CMPGT;
					else r.ucmd = `JX2_UCMD_ALU_CMPGE;
					r.regN = {`JX2_BANK_GPR, n1};
					r.regM = `JX2_REG_IMM;
					r.imm = {{(`JX2_IMM_W-4){n2 == 4'hD}}, n0};
				end
			end
			4'h3: begin
				if (n2 == 4'h0 && n0 == 4'h0 && n1 <= 4'hC) begin
					r.ucmd = `JX2_UCMD_OP_IXT;
					case (n1)
						4'h0: r.ucmd = `JX2_UCMD_NOP;
						4'h1: r.ixt.cmdIx = `JX2_UCMD_IX_RTS;
						4'h2: r.ixt.cmdIx = `JX2_UCMD_IX_SLEEP;
						4'h3: r.ixt.cmdIx = `JX2_UCMD_IX_BREAK;
						4'h4: r.ixt.cmdIx = `JX2_UCMD_IX_CLRT;
						4'h5: r.ixt.cmdIx = `JX2_UCMD_IX_SETT;
						4'h6: r.ixt.cmdIx = `JX2_UCMD_IX_CLRS;
						4'h7: r.ixt.cmdIx = `JX2_UCMD_IX_SETS;
						4'h8: r.ixt.cmdIx = `JX2_UCMD_IX_NOTT;
						4'h9: r.ixt.cmdIx = `JX2_UCMD_IX_NOTS;
						4'hA: r.ucmd = `JX2_UCMD_ALU_LDISH16;
						4'hB: begin
							r.ucmd = `JX2_UCMD_ALU_LDISH16;
							r.imm = {17'b0, 16'hFFFF};
						end
						default: r.ixt.cmdIx = `JX2_UCMD_IX_RTE;
					endcase
				end else if (n2 == 4'h3 && n0 <= 4'hA) begin
					r.ucmd = `JX2_UCMD_ALU_NOT + {4'b0, n0};
					r.regN = {`JX2_BANK_GPR, n1};
				end else if (n2 == 4'h4) begin
					r.regN = {`JX2_BANK_GPR, n1};
					if (n0 == 4'hF) begin
						r.ucmd = `JX2_UCMD_ALU_SHARSX;
						r.ixt.cmdIx = 8'd63;
					end else if (n0 >= 4'hC) begin
						r.ucmd = `JX2_UCMD_ALU_SHLLN + {4'b0, n0 - 4'hC};
						r.ixt.cmdIx = 8'd16;
					end else begin
						r.ucmd = `JX2_UCMD_ALU_SHLLN + {4'b0, n0 / 4'd4};
						r.ixt.cmdIx = 8'd1 << (n0 % 4'd4);
					end
				end else begin
					ok = 1'b0;
				end
			end
			4'hA, 4'hB: begin
				r.ucmd = `JX2_UCMD_ALU_LDIX;
				r.regN = `JX2_REG_DLR;
				r.regM = `JX2_REG_IMM;
				r.imm = {{(`JX2_IMM_W-12){n3 == 4'hB}}, w[11:0]};
			end
			4'hC, 4'hE: begin
				r.ucmd = (n3 == 4'hC) ? `JX2_UCMD_ALU_ADD : `JX2_UCMD_MOV_IR;
				r.regN = {`JX2_BANK_GPR, n2};
				r.regM = `JX2_REG_IMM;
				r.imm = {{(`JX2_IMM_W-8){w[7]}}, w[7:0]};
			end
			default: ok = 1'b0;
		endcase
		if (!ok) r = inv;
		return r;
	endfunction

	task automatic checkUCmd(input string tag, input logic [`JX2_UCMD_W-1:0] got,
			input logic [`JX2_UCMD_W-1:0] exp);
		if (got !== exp) begin
			$display("ERROR %0t: %s idUCmd %h, expected %h", $time, tag, got, exp);
			errUCmd++;
		end
	endtask

	task automatic checkReg(input string tag, input string name,
			input logic [`JX2_REG_W-1:0] got, input logic [`JX2_REG_W-1:0] exp);
		if (got !== exp) begin
			$display("ERROR %0t: %s %s %h, expected %h", $time, tag, name, got, exp);
			errReg++;
		end
	endtask

	task automatic checkImm(input string tag, input logic [`JX2_IMM_W-1:0] got,
			input logic [`JX2_IMM_W-1:0] exp);
		if (got !== exp) begin
			$display("ERROR %0t: %s idImm %h, expected %h", $time, tag, got, exp);
			errImm++;
		end
	endtask

	task automatic checkIxt(input string tag, input uIxtWord got, input uIxtWord exp);
		if (got !== exp) begin
			$display("ERROR %0t: %s idUIxt %h, expected %h", $time, tag, got, exp);
			errIxt++;
		end
	endtask

	task automatic sendWord(input logic [15:0] w);
		@(negedge clock);
		instrValid = 1'b1;
		istrWord = w;
		expQ.push_back(refDecode(w));
		sentCount++;
	endtask

	task automatic idleCycle();
		@(negedge clock);
		instrValid = 1'b0;
		istrWord = 16'h0000;
	endtask

	// Results are stable between rising edges, so they are taken at the falling edge.
	always @(negedge clock) begin
		decResult exp;
		string tag;
		if (rstN && decValid) begin
			resultCount++;
			if (expQ.size() == 0) begin
				$display("Result appeared at %0t with no word pending", $time);
				errOther++;
			end else begin
				exp = expQ.pop_front();
				tag = $sformatf("word %h", exp.word);
				checkUCmd(tag, idUCmd, exp.ucmd);
				checkReg(tag, "idRegN", idRegN, exp.regN);
				checkReg(tag, "idRegM", idRegM, exp.regM);
				checkReg(tag, "idRegO", idRegO, exp.regO);
				checkImm(tag, idImm, exp.imm);
				checkIxt(tag, idUIxt, exp.ixt);
			end
		end
	end

	initial begin
		logic [15:0] r;
		logic [15:0] g;
		instrValid = 1'b0;
		istrWord = 16'h0000;
		lfsr = 16'd14979;

		for (int i = 0; i < 20 && rstN !== 1'b1; i++) begin
			@(negedge clock);
			if (decValid !== 1'b0) begin
				$display("ERROR %0t: decValid high during reset", $time);
				errOther++;
			end
		end
		if (rstN !== 1'b1) begin
			$display("Timeout: reset was never released");
			timeouts++;
		end
		idleCycle();
		idleCycle();
		if (decValid !== 1'b0) begin
			$display("ERROR %0t: decValid high with instrValid low after reset", $time);
			errOther++;
		end
		checkUCmd("after reset", idUCmd, `JX2_UCMD_NOP);
		checkReg("after reset", "idRegN", idRegN, `JX2_REG_ZZR);
		checkReg("after reset", "idRegM", idRegM, `JX2_REG_ZZR);
		checkReg("after reset", "idRegO", idRegO, `JX2_REG_ZZR);
		checkImm("after reset", idImm, '0);
		checkIxt("after reset", idUIxt, '0);

		// Every opcode byte of groups 0x0 to 0x2, random low byte.
		for (int rep = 0; rep < 2; rep++) begin
			for (int i = 0; i < 48; i++) begin
				randBits(8, r);
				sendWord({i[7:0], r[7:0]});
			end
		end
		for (int i = 0; i < 8; i++) begin
			randBits(12, r);
			sendWord({4'hA, r[11:0]});
			randBits(12, r);
			sendWord({4'hB, r[11:0]});
			randBits(12, r);
			sendWord({4'hC, r[11:0]});
			randBits(12, r);
			sendWord({4'hE, r[11:0]});
		end
		for (int i = 0; i < 16; i++) begin
			sendWord({8'h30, i[3:0], 4'h0});
			randBits(4, r);
			sendWord({8'h33, r[3:0], i[3:0]});
			randBits(4, r);
			sendWord({8'h34, r[3:0], i[3:0]});
		end
		for (int i = 0; i < 4; i++) begin
			randBits(12, r);
			sendWord({4'h9, r[11:0]});
			randBits(12, r);
			sendWord({4'hF, r[11:0]});
			randBits(12, r);
			sendWord({4'h4, r[11:0]});
			randBits(12, r);
			sendWord({4'h8, r[11:0]});
			randBits(8, r);
			sendWord({8'h31, r[7:0]});
			randBits(4, r);
			sendWord({8'h30, r[3:0], 4'h5});
		end

		// Streaming with random gaps, about one idle cycle in four.
		for (int i = 0; i < 300; i++) begin
			randBits(16, r);
			sendWord(r);
			randBits(2, g);
			if (g[1:0] == 2'b00) idleCycle();
		end
		idleCycle();

		for (int i = 0; i < 10 && expQ.size() != 0; i++) @(negedge clock);
		if (expQ.size() != 0) begin
			$display("Timeout: %0d results never appeared", expQ.size());
			timeouts++;
		end
		if (resultCount != sentCount) begin
			$display("Result count %0d does not match %0d accepted words",
				resultCount, sentCount);
			errOther++;
		end
		$display("Results %0d/%0d, errors ucmd %0d reg %0d imm %0d ixt %0d other %0d, timeouts %0d",
			resultCount, sentCount, errUCmd, errReg, errImm, errIxt, errOther, timeouts);
		if (errUCmd + errReg + errImm + errIxt + errOther + timeouts == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+hdl
hdl/jx2DecPkg.sv
hdl/jx2OpTable.sv
hdl/jx2OperandForm.sv
hdl/jx2DecOp.sv
sim/tbClockGen.sv
sim/jx2DecOp_assert.sv
sim/tbJx2DecOp.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tbJx2DecOp -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -x "STATUS: PASS" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
